// File: test/router_golden.txt
# test src dest_x dest_y flits first_payload(hex) expected_port
# ports 0 x plus, 1 x minus, 2 y plus, 3 y minus, 4 local; router at (1,1)
routing 4 0 0 1 4000 1
routing 4 0 1 1 4001 1
routing 4 0 2 1 4002 1
routing 4 0 3 1 4003 1
routing 4 1 0 1 4010 3
routing 4 1 1 1 4011 4
routing 4 1 2 1 4012 2
routing 4 1 3 1 4013 2
routing 4 2 0 1 4020 0
routing 4 2 1 1 4021 0
routing 4 2 2 1 4022 0
routing 4 2 3 1 4023 0
routing 4 3 0 1 4030 0
routing 4 3 1 1 4031 0
routing 4 3 2 1 4032 0
routing 4 3 3 1 4033 0
multi_flit 0 0 1 4 0100 1
multi_flit 1 3 2 5 1200 0
multi_flit 0 2 2 3 0110 0
multi_flit 2 1 0 3 2300 3
multi_flit 3 1 3 6 3400 2
multi_flit 4 1 1 2 4500 4
contention 1 3 0 4 1a00 0
contention 2 2 1 4 2a00 0
contention 3 3 3 4 3a00 0
contention 1 2 3 3 1b00 0
contention 2 3 1 2 2b00 0
backpressure 0 1 0 6 0c00 3
backpressure 2 1 0 6 2c00 3
backpressure 1 1 0 5 1c00 3
backpressure 4 1 3 6 4c00 2
backpressure 4 0 0 4 4d00 1
backpressure 0 1 0 4 0d00 3
parallel 0 1 1 3 0e00 4
parallel 1 2 2 3 1e00 0
parallel 2 0 3 3 2e00 1
parallel 3 1 3 3 3e00 2
parallel 4 1 0 3 4e00 3

// File: tb.f
hw/noc_pkg.sv
hw/flit_if.sv
hw/input_fifo.sv
hw/route_unit.sv
hw/output_switch.sv
hw/mesh_router.sv
test/router_tb.sv

// File: Bender.yml
package:
  name: mesh_router

sources:
  - hw/noc_pkg.sv
  - hw/flit_if.sv
  - hw/input_fifo.sv
  - hw/route_unit.sv
  - hw/output_switch.sv
  - hw/mesh_router.sv
  - target: test
    files:
      - test/router_tb.sv

// File: test/router_tb.sv
`timescale 1ns/1ps
`default_nettype none

module router_tb
  import noc_pkg::*;
();

  localparam int max_flits = 64;

  logic  clk;
  logic  reset;
  logic  in_valid  [num_ports];
  logic  in_ready  [num_ports];
  flit_t in_flit   [num_ports];
  logic  out_valid [num_ports];
  logic  out_ready [num_ports];
  flit_t out_flit  [num_ports];

  // Flits still to send per input and expected flits per output and source
  flit_t src_flits [num_ports][max_flits];
  int    src_len   [num_ports];
  int    src_pos   [num_ports];
  flit_t exp_flits [num_ports][num_ports][max_flits];
  int    exp_wr    [num_ports][num_ports];
  int    exp_rd    [num_ports][num_ports];
  int    open_src  [num_ports];
  logic  stalled   [num_ports];
  flit_t held_flit [num_ports];

  logic [31:0] lfsr;
  int          cycle_count  = 0;
  int          cycle_limit  = 0;
  int          test_errs    = 0;
  int          err_total    = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;

  mesh_router #(
    .router_x   (2'd1),
    .router_y   (2'd1),
    .fifo_depth (4)
  ) uut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count > 0 && cycle_count >= cycle_limit);
    $display("timeout: traffic still in flight after %0d cycles", cycle_count);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // XY order for a router at (1,1)
  function automatic int xy_port(input int dx, input int dy);
    if (dx != 1) return (dx > 1) ? port_x_plus : port_x_minus;
    if (dy != 1) return (dy > 1) ? port_y_plus : port_y_minus;
    return port_local;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      test_errs++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    test_errs++;
  endtask

  task automatic close_test(input string name, input int flits);
    $display("test %s: %0d flits, %0d errors", name, flits, test_errs);
    tests_run++;
    err_total += test_errs;
    if (test_errs != 0) tests_failed++;
    test_errs = 0;
    for (int i = 0; i < num_ports; i++) begin
      src_len[i]  = 0;
      src_pos[i]  = 0;
      open_src[i] = -1;
      stalled[i]  = 1'b0;
      for (int s = 0; s < num_ports; s++) begin
        exp_wr[i][s] = 0;
        exp_rd[i][s] = 0;
      end
    end
  endtask

  task automatic add_packet(input string name, input int src, input int dx, input int dy,
                            input int len, input payload_t pay, input int port);
    flit_t f;
    check_value(name, xy_port(dx, dy), port);
    for (int k = 0; k < len; k++) begin
      f = {k == 0, k == len - 1, coord_t'(dx), coord_t'(dy), payload_t'(pay + k)};
      src_flits[src][src_len[src]] = f;
      src_len[src]++;
      exp_flits[port][src][exp_wr[port][src]] = f;
      exp_wr[port][src]++;
    end
  endtask

  task automatic run_test(input string name, input int flits);
    logic fire_in [num_ports];
    logic bp;
    logic saw_full;
    int   remaining;
    int   fired;
    int   peak;
    int   src;
    bp        = (name == "backpressure");
    saw_full  = 1'b0;
    remaining = flits;
    peak      = 0;
    cycle_limit += 4 * flits;
    while (remaining > 0) begin
      for (int i = 0; i < num_ports; i++) begin
        in_valid[i]  = src_pos[i] < src_len[i];
        in_flit[i]   = src_flits[i][src_pos[i]];
        out_ready[i] = bp ? lfsr[0] : 1'b1;
        if (bp) lfsr = lfsr_step(lfsr);
      end
      // Sample between edges where inputs and outputs are settled
      @(negedge clk);
      fired = 0;
      for (int i = 0; i < num_ports; i++) begin
        fire_in[i] = in_valid[i] && in_ready[i];
        saw_full   = saw_full || !in_ready[i];
        if (stalled[i] && (!out_valid[i] || out_flit[i] !== held_flit[i])) begin
          report_failure($sformatf("output %0d changed while stalled in %s", i, name));
        end
        stalled[i]   = out_valid[i] && !out_ready[i];
        held_flit[i] = out_flit[i];
        if (out_valid[i] && out_ready[i]) begin
          src = int'(out_flit[i][15:12]);
          fired++;
          if (src >= num_ports || exp_rd[i][src] == exp_wr[i][src]) begin
            report_failure($sformatf("unexpected flit %h on output %0d in %s",
                                     out_flit[i], i, name));
          end else begin
            check_value(name, exp_flits[i][src][exp_rd[i][src]], out_flit[i]);
            exp_rd[i][src]++;
            remaining--;
          end
          if (open_src[i] >= 0 && open_src[i] != src) begin
            report_failure($sformatf("packets interleaved on output %0d in %s", i, name));
          end
          open_src[i] = out_flit[i][flit_tail_bit] ? -1 : src;
        end
      end
      peak = (fired > peak) ? fired : peak;
      @(posedge clk);
      #2;
      for (int i = 0; i < num_ports; i++) begin
        if (fire_in[i]) src_pos[i]++;
      end
    end
    for (int i = 0; i < num_ports; i++) begin
      in_valid[i]  = 1'b0;
      out_ready[i] = 1'b1;
    end
    if (bp && !saw_full) report_failure("in_ready never fell under back-pressure");
    if (name == "parallel") check_value(name, num_ports, peak);
    close_test(name, flits);
  endtask

  initial begin
    int       fd;
    int       n;
    int       flits;
    int       src;
    int       dx;
    int       dy;
    int       len;
    int       port;
    string    line;
    string    name;
    string    cur;
    payload_t pay;
    reset       = 1'b1;
    lfsr        = 32'h0b7f_bcbb;
    cycle_limit = 200;
    for (int i = 0; i < num_ports; i++) begin
      in_valid[i]  = 1'b0;
      in_flit[i]   = '0;
      out_ready[i] = 1'b1;
    end
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    for (int i = 0; i < num_ports; i++) begin
      check_value("reset_state", 0, out_valid[i]);
      check_value("reset_state", 1, in_ready[i]);
    end
    close_test("reset_state", 0);
    @(posedge clk);
    #2;
    fd = $fopen("test/router_golden.txt", "r");
    if (fd == 0) begin
      report_failure("golden file test/router_golden.txt could not be opened");
      close_test("golden_file", 0);
    end else begin
      cur   = "";
      flits = 0;
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %d %d %d %d %h %d", name, src, dx, dy, len, pay, port);
        end else begin
          n = 0;
        end
        if (n == 7) begin
          // A new test name closes the packets gathered so far
          if (name != cur && cur != "") begin
            run_test(cur, flits);
            flits = 0;
          end
          cur = name;
          add_packet(name, src, dx, dy, len, pay, port);
          flits += len;
        end
      end
      $fclose(fd);
      if (cur != "") begin
        run_test(cur, flits);
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, err_total);
    if (err_total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router
  import noc_pkg::*;
#(
  parameter coord_t router_x   = '0,
  parameter coord_t router_y   = '0,
  parameter int     fifo_depth = 4
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid  [num_ports],
  output logic  in_ready  [num_ports],
  input  flit_t in_flit   [num_ports],
  output logic  out_valid [num_ports],
  input  logic  out_ready [num_ports],
  output flit_t out_flit  [num_ports]
);

  // One routed stream per input and every output switch sees all five
  flit_if routed [num_ports] ();

  for (genvar i = 0; i < num_ports; i++) begin : g_input
    logic  q_valid;
    logic  q_ready;
    flit_t q_flit;

    input_fifo #(
      .fifo_depth (fifo_depth)
    ) u_fifo (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid[i]),
      .in_ready  (in_ready[i]),
      .in_flit   (in_flit[i]),
      .out_valid (q_valid),
      .out_ready (q_ready),
      .out_flit  (q_flit)
    );

    route_unit #(
      .router_x (router_x),
      .router_y (router_y)
    ) u_route (
      .clk      (clk),
      .reset    (reset),
      .in_valid (q_valid),
      .in_ready (q_ready),
      .in_flit  (q_flit),
      .out      (routed[i])
    );
  end

  for (genvar o = 0; o < num_ports; o++) begin : g_output
    output_switch #(
      .port_id (o)
    ) u_switch (
      .clk       (clk),
      .reset     (reset),
      .in        (routed),
      .out_valid (out_valid[o]),
      .out_ready (out_ready[o]),
      .out_flit  (out_flit[o])
    );
  end

endmodule

`default_nettype wire

// File: hw/output_switch.sv
`timescale 1ns/1ps
`default_nettype none

module output_switch
  import noc_pkg::*;
#(
  parameter int port_id = port_local
) (
  input  logic  clk,
  input  logic  reset,
  flit_if.sink  in [num_ports],
  output logic  out_valid,
  input  logic  out_ready,
  output flit_t out_flit
);

  arb_state_t state;
  port_idx_t  rr_ptr;
  port_idx_t  lock_idx;
  port_idx_t  pick_idx;
  port_idx_t  grant_idx;
  port_mask_t req_valid;
  port_mask_t head_req;
  port_mask_t grant;
  flit_t      req_flit [num_ports];
  logic       found;
  logic       reg_free;
  logic       xfer;
  logic       xfer_tail;

  for (genvar i = 0; i < num_ports; i++) begin : g_in
    assign req_valid[i]         = in[i].valid && in[i].request[port_id];
    assign head_req[i]          = req_valid[i] && flit_is_head(in[i].flit);
    assign req_flit[i]          = in[i].flit;
    assign in[i].grant[port_id] = grant[i];
  end

  // First head request at or after the round-robin pointer
  always_comb begin
    int idx;
    found    = 1'b0;
    pick_idx = '0;
    for (int k = 0; k < num_ports; k++) begin
      idx = (int'(rr_ptr) + k) % num_ports;
      if (!found && head_req[idx]) begin
        found    = 1'b1;
        pick_idx = port_idx_t'(idx);
      end
    end
  end

  // Register takes a new flit on the edge the old one leaves
  assign reg_free = !out_valid || out_ready;

  always_comb begin
    grant = '0;
    if (reg_free) begin
      if (state == arb_idle) begin
        if (found) begin
          grant[pick_idx] = 1'b1;
        end
      end else if (req_valid[lock_idx]) begin
        grant[lock_idx] = 1'b1;
      end
    end
  end

  assign grant_idx = (state == arb_idle) ? pick_idx : lock_idx;
  assign xfer      = |grant;
  assign xfer_tail = flit_is_tail(req_flit[grant_idx]);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= arb_idle;
      rr_ptr   <= '0;
      lock_idx <= '0;
    end else if (xfer) begin
      if (xfer_tail) begin
        state  <= arb_idle;
        rr_ptr <= (grant_idx == port_idx_t'(num_ports - 1)) ? '0 : grant_idx + 1'b1;
      end else begin
        state    <= arb_locked;
        lock_idx <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (xfer) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      out_flit <= req_flit[grant_idx];
    end
  end

  // An input is never granted by two output switches at once
  for (genvar i = 0; i < num_ports; i++) begin : g_grant_chk
    a_single_grant: assert property (@(posedge clk) disable iff (reset)
      $onehot0(in[i].grant));
  end

  // Stalled output keeps its flit
  a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

`default_nettype wire

// File: hw/route_unit.sv
`timescale 1ns/1ps
`default_nettype none

module route_unit
  import noc_pkg::*;
#(
  parameter coord_t router_x = '0,
  parameter coord_t router_y = '0
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   in_valid,
  output logic   in_ready,
  input  flit_t  in_flit,
  flit_if.source out
);

  port_mask_t head_route;
  port_mask_t held_route;
  logic       xfer;

  // X is resolved first and y only once x matches
  always_comb begin
    coord_t dx;
    coord_t dy;
    dx = flit_dest_x(in_flit);
    dy = flit_dest_y(in_flit);
    head_route = '0;
    if (dx > router_x) begin
      head_route[port_x_plus] = 1'b1;
    end else if (dx < router_x) begin
      head_route[port_x_minus] = 1'b1;
    end else if (dy > router_y) begin
      head_route[port_y_plus] = 1'b1;
    end else if (dy < router_y) begin
      head_route[port_y_minus] = 1'b1;
    end else begin
      head_route[port_local] = 1'b1;
    end
  end

  assign out.valid   = in_valid;
  assign out.flit    = in_flit;
  assign out.request = flit_is_head(in_flit) ? head_route : held_route;

  assign in_ready = out.ready;
  assign xfer     = in_valid && out.ready;

  // Body flits follow the route of their head
  always_ff @(posedge clk) begin
    if (reset) begin
      held_route <= '0;
    end else if (xfer) begin
      if (flit_is_tail(in_flit)) begin
        held_route <= '0;
      end else if (flit_is_head(in_flit)) begin
        held_route <= head_route;
      end
    end
  end

  // Also catches a body flit with no open packet
  a_request_onehot: assert property (@(posedge clk) disable iff (reset)
    out.valid |-> $onehot(out.request));

endmodule

`default_nettype wire

// File: hw/input_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module input_fifo
  import noc_pkg::*;
#(
  parameter int fifo_depth = 4
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  output logic  in_ready,
  input  flit_t in_flit,
  output logic  out_valid,
  input  logic  out_ready,
  output flit_t out_flit
);

  localparam int ptr_w = $clog2(fifo_depth);
  localparam int cnt_w = $clog2(fifo_depth + 1);

  flit_t            mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             do_write;
  logic             do_read;

  assign full      = (count == cnt_w'(fifo_depth));
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

  // Full still takes a flit when the head leaves on the same edge
  assign in_ready = !full || out_ready;

  assign do_write = in_valid && in_ready;
  assign do_read  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Data shows up only after the edge that wrote it
  a_no_early_read: assert property (@(posedge clk) disable iff (reset)
    (count == '0) && !do_write |=> !out_valid);

  // A full FIFO with no read leaves the write side untouched
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    full && !do_read |=> full && $stable(wr_ptr));

endmodule

`default_nettype wire

// File: hw/flit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface flit_if
  import noc_pkg::*;
();

  logic       valid;
  logic       ready;
  flit_t      flit;
  port_mask_t request;

  // One bit per output switch and each bit driven by that switch
  wire port_mask_t grant;

  // Only the output named in request can raise its bit
  assign ready = |grant;

  modport source (
    output valid,
    output flit,
    output request,
    input  ready
  );

  modport sink (
    input  valid,
    input  flit,
    input  request,
    output grant
  );

endinterface

`default_nettype wire

// File: hw/noc_pkg.sv
`default_nettype none

package noc_pkg;

  localparam int num_ports = 5;

  // Port order of the mesh environment
  localparam int port_x_plus  = 0;
  localparam int port_x_minus = 1;
  localparam int port_y_plus  = 2;
  localparam int port_y_minus = 3;
  localparam int port_local   = 4;

  localparam int coord_w   = 2;
  localparam int payload_w = 16;
  localparam int flit_w    = 2 + 2 * coord_w + payload_w;

  // Head and tail flags sit above the destination and payload
  localparam int flit_head_bit   = 21;
  localparam int flit_tail_bit   = 20;
  localparam int flit_dest_x_lsb = 18;
  localparam int flit_dest_y_lsb = 16;

  typedef logic [coord_w-1:0]           coord_t;
  typedef logic [payload_w-1:0]         payload_t;
  typedef logic [flit_w-1:0]            flit_t;
  typedef logic [num_ports-1:0]         port_mask_t;
  typedef logic [$clog2(num_ports)-1:0] port_idx_t;

  typedef enum logic {
    arb_idle,
    arb_locked
  } arb_state_t;

  function automatic logic flit_is_head(flit_t f);
    return f[flit_head_bit];
  endfunction

  function automatic logic flit_is_tail(flit_t f);
    return f[flit_tail_bit];
  endfunction

  function automatic coord_t flit_dest_x(flit_t f);
    return f[flit_dest_x_lsb +: coord_w];
  endfunction

  function automatic coord_t flit_dest_y(flit_t f);
    return f[flit_dest_y_lsb +: coord_w];
  endfunction

  function automatic flit_t make_flit(logic head, logic tail, coord_t dx, coord_t dy,
                                      payload_t data);
    return {head, tail, dx, dy, data};
  endfunction

endpackage

`default_nettype wire
